/* Bender.yml */
package:
  name: xcom

sources:
  - common/xcom_cmd_pkg.sv
  - common/xcom_link_pkg.sv
  - xcom_tx/xcom_tx_ser.sv
  - xcom_rx/xcom_rx_deser.sv
  - src/xcom_exec.sv
  - src/xcom_top.sv
  - target: simulation
    files:
      - dv/xcom_tb.sv

/* common/xcom_cmd_pkg.sv */
// command set of the serial link
// header layout: opcode in [7:4], payload length code in [6:5], argument in [3:0]
// opcode and length fields overlap, so a sender must pick matching codes
// unknown opcodes are ignored by the executor
package xcom_cmd_pkg;

  ////////////////////////////////////////////////////////////
  // header field positions
  ////////////////////////////////////////////////////////////
  localparam int unsigned HDR_W       = 8;
  localparam int unsigned HDR_OP_MSB  = 7;
  localparam int unsigned HDR_OP_LSB  = 4;
  localparam int unsigned HDR_LEN_MSB = 6;
  localparam int unsigned HDR_LEN_LSB = 5;
  // id, memory address or register select
  localparam int unsigned HDR_ARG_MSB = 3;
  localparam int unsigned HDR_SEL_BIT = 0;

  typedef logic [HDR_W-1:0] header_t;
  typedef logic [3:0]       opcode_t;
  typedef logic [1:0]       len_code_t;

  // opcodes
  localparam opcode_t XCOM_SET_ID     = 4'd0;
  localparam opcode_t XCOM_WRITE_FLAG = 4'd1;
  localparam opcode_t XCOM_WRITE_REG  = 4'd2;
  localparam opcode_t XCOM_WRITE_MEM  = 4'd3;

  // payload length codes
  localparam len_code_t LEN_NONE = 2'd0;
  localparam len_code_t LEN_8    = 2'd1;
  localparam len_code_t LEN_16   = 2'd2;
  localparam len_code_t LEN_32   = 2'd3;

endpackage

/* common/xcom_link_pkg.sv */
// widths and limits of the serial link and the register state
// tick values above 7 are outside the supported range
// memory address 15 has no storage behind it
package xcom_link_pkg;

  localparam int unsigned WORD_W      = 32;
  localparam int unsigned TICK_W      = 4;
  localparam int unsigned ID_W        = 4;
  localparam int unsigned ADDR_W      = 4;
  localparam int unsigned MEM_DEPTH   = 15;
  localparam int unsigned SYNC_STAGES = 2;

  // start bit, 8-bit header, longest payload
  localparam int unsigned FRAME_W   = 1 + 8 + WORD_W;
  localparam int unsigned BIT_CNT_W = $clog2(FRAME_W + 1);

  typedef logic [WORD_W-1:0]    word_t;
  // half-period is tick + 2 clock cycles
  typedef logic [TICK_W-1:0]    tick_t;
  typedef logic [ID_W-1:0]      board_id_t;
  typedef logic [ADDR_W-1:0]    mem_addr_t;
  typedef logic [BIT_CNT_W-1:0] bit_cnt_t;

endpackage

/* dv/xcom_tb.sv */
// loopback testbench for the serial command link
// o_xcom_clk and o_xcom_data feed straight back into the receiver
// i_cfg_tick only changes while the transmitter is idle
// network headers keep bit 7 clear, so only LEN_8 frames reach the
// register and memory opcodes, longer payloads are checked at the receiver
module xcom_tb
  import xcom_cmd_pkg::*;
  import xcom_link_pkg::*;
();

  localparam int unsigned TIMEOUT = 2000;

  logic      c_clk_i;
  logic      c_rst_ni;
  tick_t     i_cfg_tick;
  logic      i_req_loc;
  logic      i_req_net;
  header_t   i_header;
  word_t     i_data;
  mem_addr_t i_mem_addr;
  logic      o_ack_loc;
  logic      o_ack_net;
  word_t     o_mem_data;
  logic      o_qp_vld;
  logic      o_qp_flag;
  word_t     o_qp_dt1;
  word_t     o_qp_dt2;
  board_id_t o_board_id;
  logic      xcom_clk;
  logic      xcom_data;
  logic      o_tx_busy;

  // reference state, built from the command rules
  board_id_t   exp_id;
  logic        exp_flag;
  word_t       exp_dt1;
  word_t       exp_dt2;
  word_t       exp_mem [16];
  int          exp_vld = 0;
  int          vld_cnt = 0;
  logic [39:0] exp_frames [$];
  string       test_name = "init";
  int          err_cnt = 0;
  int          test_err0 = 0;
  int          test_cnt = 0;
  int          fail_cnt = 0;
  logic        clk_seen;
  logic        armed;
  logic [4:0]  since_toggle;

  xcom_top DUT (
    .c_clk_i    (c_clk_i),
    .c_rst_ni   (c_rst_ni),
    .i_cfg_tick (i_cfg_tick),
    .i_req_loc  (i_req_loc),
    .o_ack_loc  (o_ack_loc),
    .i_req_net  (i_req_net),
    .o_ack_net  (o_ack_net),
    .i_header   (i_header),
    .i_data     (i_data),
    .i_mem_addr (i_mem_addr),
    .o_mem_data (o_mem_data),
    .o_qp_vld   (o_qp_vld),
    .o_qp_flag  (o_qp_flag),
    .o_qp_dt1   (o_qp_dt1),
    .o_qp_dt2   (o_qp_dt2),
    .o_board_id (o_board_id),
    .i_xcom_clk (xcom_clk),
    .i_xcom_data(xcom_data),
    .o_xcom_clk (xcom_clk),
    .o_xcom_data(xcom_data),
    .o_tx_busy  (o_tx_busy)
  );

  always #2 c_clk_i = ~c_clk_i;

  ////////////////////////////////////////////////////////////
  // reporting and reference model
  ////////////////////////////////////////////////////////////
  function automatic void report_error(input string msg);
    $display("ERROR in %s: %s", test_name, msg);
    err_cnt++;
  endfunction

  task automatic check_word(input string what, input word_t exp, input word_t act);
    assert (act === exp) else begin
      $display("FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("TIMEOUT in %s: %s never happened", test_name, what);
    $display("Simulation failed");
    $finish;
  endtask

  // bit 7 clear, length code in 6..5
  function automatic header_t make_hdr(input len_code_t len, input logic b4,
                                       input logic [3:0] arg);
    return {1'b0, len, b4, arg};
  endfunction

  // low bits of the word, zero-extended
  function automatic word_t net_payload(input header_t hdr, input word_t dat);
    case (len_code_t'(hdr[6:5]))
      LEN_NONE: return '0;
      LEN_8:    return {24'd0, dat[7:0]};
      LEN_16:   return {16'd0, dat[15:0]};
      default:  return dat;
    endcase
  endfunction

  function automatic void model_exec(input header_t hdr, input word_t pay);
    case (opcode_t'(hdr[7:4]))
      XCOM_SET_ID:     exp_id = hdr[3:0];
      XCOM_WRITE_FLAG: exp_flag = hdr[0];
      XCOM_WRITE_REG: begin
        exp_vld++;
        if (hdr[0]) begin
          exp_dt2 = pay;
        end else begin
          exp_dt1 = pay;
        end
      end
      XCOM_WRITE_MEM: begin
        if (hdr[3:0] < MEM_DEPTH) exp_mem[hdr[3:0]] = pay;
      end
      default: ;
    endcase
  endfunction

  task automatic start_test(input string name);
    test_name = name;
    test_err0 = err_cnt;
  endtask

  task automatic end_test();
    test_cnt++;
    if (err_cnt == test_err0) begin
      $display("test %-10s ok", test_name);
    end else begin
      fail_cnt++;
      $display("test %-10s %0d errors", test_name, err_cnt - test_err0);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // handshakes and waits
  ////////////////////////////////////////////////////////////
  task automatic run_local(input header_t hdr, input word_t dat, input int exp_lat);
    int n;
    model_exec(hdr, dat);
    i_header  <= hdr;
    i_data    <= dat;
    i_req_loc <= 1'b1;
    n = 0;
    while (o_ack_loc !== 1'b1 && n < TIMEOUT) begin
      @(posedge c_clk_i);
      n++;
    end
    if (n >= TIMEOUT) abort_on_timeout("local ack rise");
    check_word("local ack latency", exp_lat, n);
    i_req_loc <= 1'b0;
    n = 0;
    while (o_ack_loc !== 1'b0 && n < TIMEOUT) begin
      @(posedge c_clk_i);
      n++;
    end
    if (n >= TIMEOUT) abort_on_timeout("local ack fall");
  endtask

  task automatic send_net(input header_t hdr, input word_t dat);
    int n;
    exp_frames.push_back({hdr, net_payload(hdr, dat)});
    model_exec(hdr, net_payload(hdr, dat));
    i_header  <= hdr;
    i_data    <= dat;
    i_req_net <= 1'b1;
    n = 0;
    while (o_ack_net !== 1'b1 && n < TIMEOUT) begin
      @(posedge c_clk_i);
      n++;
    end
    if (n >= TIMEOUT) abort_on_timeout("network ack rise");
    i_req_net <= 1'b0;
    n = 0;
    while (o_ack_net !== 1'b0 && n < TIMEOUT) begin
      @(posedge c_clk_i);
      n++;
    end
    if (n >= TIMEOUT) abort_on_timeout("network ack fall");
  endtask

  // all sent frames received and the line idle
  task automatic wait_frames_done();
    int n;
    n = 0;
    while ((exp_frames.size() != 0 || o_tx_busy) && n < TIMEOUT) begin
      @(posedge c_clk_i);
      n++;
    end
    if (n >= TIMEOUT) abort_on_timeout("frame reception");
  endtask

  // register outputs, full memory sweep, valid pulse count
  task automatic check_state();
    @(negedge c_clk_i);
    check_word("board id", exp_id, o_board_id);
    check_word("flag", exp_flag, o_qp_flag);
    check_word("dt1", exp_dt1, o_qp_dt1);
    check_word("dt2", exp_dt2, o_qp_dt2);
    for (int a = 0; a < 16; a++) begin
      @(posedge c_clk_i);
      i_mem_addr <= mem_addr_t'(a);
      @(negedge c_clk_i);
      check_word($sformatf("mem[%0d]", a), exp_mem[a], o_mem_data);
    end
    check_word("qp_vld pulses", exp_vld, vld_cnt);
    @(posedge c_clk_i);
  endtask

  ////////////////////////////////////////////////////////////
  // monitors
  ////////////////////////////////////////////////////////////
  a_loc_rise: assert property (@(posedge c_clk_i) disable iff (!c_rst_ni)
    $rose(o_ack_loc) |-> $past(i_req_loc))
    else report_error("local ack rose while its request was low");
  a_loc_fall: assert property (@(posedge c_clk_i) disable iff (!c_rst_ni)
    $fell(o_ack_loc) |-> !$past(i_req_loc))
    else report_error("local ack fell while its request was still high");
  a_net_rise: assert property (@(posedge c_clk_i) disable iff (!c_rst_ni)
    $rose(o_ack_net) |-> $past(i_req_net) && !$past(o_tx_busy))
    else report_error("network ack rose without a request or during a frame");
  a_net_fall: assert property (@(posedge c_clk_i) disable iff (!c_rst_ni)
    $fell(o_ack_net) |-> !$past(i_req_net))
    else report_error("network ack fell while its request was still high");
  a_clk_idle: assert property (@(posedge c_clk_i) disable iff (!c_rst_ni)
    !o_tx_busy |-> !xcom_clk)
    else report_error("serial clock high while the transmitter is idle");

  // toggle spacing, first toggle of a frame not checked
  always @(posedge c_clk_i or negedge c_rst_ni) begin
    if (!c_rst_ni) begin
      clk_seen     <= 1'b0;
      armed        <= 1'b0;
      since_toggle <= '0;
    end else begin
      if (xcom_clk != clk_seen) begin
        if (armed) check_word("toggle spacing", word_t'(i_cfg_tick) + 2, since_toggle);
        since_toggle <= 5'd1;
      end else if (since_toggle != 5'd31) begin
        since_toggle <= since_toggle + 5'd1;
      end
      clk_seen <= xcom_clk;
      if (!o_tx_busy) begin
        armed <= 1'b0;
      end else if (xcom_clk != clk_seen) begin
        armed <= 1'b1;
      end
    end
  end

  // received frames in send order, valid pulse count
  always @(negedge c_clk_i) begin
    if (c_rst_ni && o_qp_vld) vld_cnt++;
    if (c_rst_ni && DUT.rx_valid) begin
      if (exp_frames.size() == 0) begin
        report_error("a frame arrived that was never sent");
      end else begin
        check_word("rx header", word_t'(exp_frames[0][39:32]), word_t'(DUT.rx_header));
        check_word("rx payload", exp_frames[0][31:0], DUT.rx_data);
        void'(exp_frames.pop_front());
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    int n;
    void'($urandom(32'h947b_917d));
    c_clk_i    = 1'b0;
    c_rst_ni   = 1'b0;
    i_cfg_tick = tick_t'(1);
    i_req_loc  = 1'b0;
    i_req_net  = 1'b0;
    i_header   = '0;
    i_data     = '0;
    i_mem_addr = '0;
    exp_id     = '0;
    exp_flag   = 1'b0;
    exp_dt1    = '0;
    exp_dt2    = '0;
    for (int a = 0; a < 16; a++) exp_mem[a] = '0;
    repeat (10) @(posedge c_clk_i);
    c_rst_ni <= 1'b1;
    @(posedge c_clk_i);

    start_test("reset");
    @(negedge c_clk_i);
    check_word("ack_loc", 0, o_ack_loc);
    check_word("ack_net", 0, o_ack_net);
    check_word("qp_vld", 0, o_qp_vld);
    check_word("xcom_clk", 0, xcom_clk);
    check_word("xcom_data", 0, xcom_data);
    check_word("tx_busy", 0, o_tx_busy);
    @(posedge c_clk_i);
    check_state();
    end_test();

    start_test("local");
    run_local({XCOM_SET_ID, 4'($urandom_range(1, 15))}, $urandom, 2);
    run_local({XCOM_WRITE_FLAG, 4'd1}, $urandom, 2);
    run_local({XCOM_WRITE_REG, 4'd0}, $urandom, 2);
    run_local({XCOM_WRITE_REG, 4'd1}, $urandom, 2);
    for (int i = 0; i < 4; i++) begin
      run_local({XCOM_WRITE_MEM, 4'($urandom_range(0, 14))}, $urandom, 2);
    end
    // no storage behind address 15
    run_local({XCOM_WRITE_MEM, 4'd15}, $urandom, 2);
    check_state();
    end_test();

    // every length code, both values of bit 4
    start_test("network");
    for (int i = 0; i < 16; i++) begin
      send_net(make_hdr(len_code_t'((i % 8) / 2), i[0], 4'($urandom_range(0, 15))),
               $urandom);
      wait_frames_done();
    end
    check_state();
    end_test();

    start_test("bit period");
    for (int i = 0; i < 6; i++) begin
      i_cfg_tick <= tick_t'($urandom_range(0, 7));
      @(posedge c_clk_i);
      send_net(make_hdr(len_code_t'($urandom_range(0, 3)), 1'b1,
                        4'($urandom_range(0, 15))), $urandom);
      wait_frames_done();
    end
    check_state();
    end_test();

    start_test("handshake");
    send_net(make_hdr(LEN_32, 1'b0, 4'd0), $urandom);
    // second request raised mid-frame
    check_word("tx busy at second request", 1, o_tx_busy);
    send_net(make_hdr(LEN_8, 1'b0, 4'd1), $urandom);
    wait_frames_done();
    send_net(make_hdr(LEN_8, 1'b0, 4'd0), $urandom);
    // local request lands on the rx_valid cycle
    n = 0;
    while (DUT.u_rx_deser.frame_done !== 1'b1 && n < TIMEOUT) begin
      @(posedge c_clk_i);
      n++;
    end
    if (n >= TIMEOUT) abort_on_timeout("end of received frame");
    run_local({XCOM_WRITE_MEM, 4'($urandom_range(0, 14))}, $urandom, 3);
    wait_frames_done();
    check_state();
    end_test();

    $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* src/xcom_exec.sv */
// command executor for local and received commands
// a received frame always executes at once, a local command waits one cycle
// i_header and i_data must stay stable while i_req_loc is high
// memory writes to address 15 are dropped, reads there return zero
module xcom_exec
  import xcom_cmd_pkg::*;
  import xcom_link_pkg::*;
(
  input  logic      c_clk_i,
  input  logic      c_rst_ni,
  input  logic      i_req_loc,
  output logic      o_ack_loc,
  input  header_t   i_header,
  input  word_t     i_data,
  input  logic      i_rx_valid,
  input  header_t   i_rx_header,
  input  word_t     i_rx_data,
  input  mem_addr_t i_mem_addr,
  output word_t     o_mem_data,
  output logic      o_qp_vld,
  output logic      o_qp_flag,
  output word_t     o_qp_dt1,
  output word_t     o_qp_dt2,
  output board_id_t o_board_id
);

  logic      loc_exec;
  logic      exec_en;
  header_t   cmd_hdr;
  word_t     cmd_data;
  opcode_t   cmd_op;
  mem_addr_t cmd_addr;
  logic      wr_id;
  logic      wr_flag;
  logic      wr_reg;
  logic      wr_mem;
  word_t     mem_q [MEM_DEPTH];

  ////////////////////////////////////////////////////////////
  // source select, receiver first
  ////////////////////////////////////////////////////////////
  assign loc_exec = i_req_loc & ~o_ack_loc & ~i_rx_valid;
  assign exec_en  = i_rx_valid | loc_exec;

  assign cmd_hdr  = i_rx_valid ? i_rx_header : i_header;
  assign cmd_data = i_rx_valid ? i_rx_data : i_data;
  assign cmd_op   = cmd_hdr[HDR_OP_MSB:HDR_OP_LSB];
  assign cmd_addr = cmd_hdr[HDR_ARG_MSB:0];

  // opcode decode
  assign wr_id   = exec_en && (cmd_op == XCOM_SET_ID);
  assign wr_flag = exec_en && (cmd_op == XCOM_WRITE_FLAG);
  assign wr_reg  = exec_en && (cmd_op == XCOM_WRITE_REG);
  assign wr_mem  = exec_en && (cmd_op == XCOM_WRITE_MEM);

  // local ack, rises after execution and follows the request down
  always_ff @(posedge c_clk_i or negedge c_rst_ni) begin
    if (!c_rst_ni) begin
      o_ack_loc <= 1'b0;
    end else if (loc_exec) begin
      o_ack_loc <= 1'b1;
    end else if (!i_req_loc && o_ack_loc) begin
      o_ack_loc <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // register state
  ////////////////////////////////////////////////////////////
  always_ff @(posedge c_clk_i or negedge c_rst_ni) begin
    if (!c_rst_ni) begin
      o_board_id <= '0;
      o_qp_flag  <= 1'b0;
      o_qp_dt1   <= '0;
      o_qp_dt2   <= '0;
      o_qp_vld   <= 1'b0;
    end else begin
      // valid follows any data register write by one cycle
      o_qp_vld <= wr_reg;
      if (wr_id) o_board_id <= cmd_hdr[HDR_ARG_MSB:0];
      if (wr_flag) o_qp_flag <= cmd_hdr[HDR_SEL_BIT];
      if (wr_reg) begin
        if (cmd_hdr[HDR_SEL_BIT]) begin
          o_qp_dt2 <= cmd_data;
        end else begin
          o_qp_dt1 <= cmd_data;
        end
      end
    end
  end

  // memory, cleared on reset so reads start at zero
  always_ff @(posedge c_clk_i or negedge c_rst_ni) begin
    if (!c_rst_ni) begin
      mem_q <= '{default: '0};
    end else if (wr_mem && (cmd_addr < MEM_DEPTH)) begin
      mem_q[cmd_addr] <= cmd_data;
    end
  end

  // combinational read port
  assign o_mem_data = (i_mem_addr < MEM_DEPTH) ? mem_q[i_mem_addr] : '0;

endmodule

/* src/xcom_top.sv */
// serial command link, transmitter, receiver and executor side by side
// both handshakes share i_header and i_data
// only one request may be raised at a time
module xcom_top
  import xcom_cmd_pkg::*;
  import xcom_link_pkg::*;
(
  input  logic      c_clk_i,
  input  logic      c_rst_ni,
  input  tick_t     i_cfg_tick,
  // local and network command ports
  input  logic      i_req_loc,
  output logic      o_ack_loc,
  input  logic      i_req_net,
  output logic      o_ack_net,
  input  header_t   i_header,
  input  word_t     i_data,
  // register state
  input  mem_addr_t i_mem_addr,
  output word_t     o_mem_data,
  output logic      o_qp_vld,
  output logic      o_qp_flag,
  output word_t     o_qp_dt1,
  output word_t     o_qp_dt2,
  output board_id_t o_board_id,
  // serial link
  input  logic      i_xcom_clk,
  input  logic      i_xcom_data,
  output logic      o_xcom_clk,
  output logic      o_xcom_data,
  output logic      o_tx_busy
);

  logic    rx_valid;
  header_t rx_header;
  word_t   rx_data;

  ////////////////////////////////////////////////////////////
  // transmit side
  ////////////////////////////////////////////////////////////
  xcom_tx_ser u_tx_ser (
    .c_clk_i    (c_clk_i),
    .c_rst_ni   (c_rst_ni),
    .i_cfg_tick (i_cfg_tick),
    .i_req      (i_req_net),
    .i_header   (i_header),
    .i_data     (i_data),
    .o_ack      (o_ack_net),
    .o_busy     (o_tx_busy),
    .o_xcom_clk (o_xcom_clk),
    .o_xcom_data(o_xcom_data)
  );

  ////////////////////////////////////////////////////////////
  // receive side and command execution
  ////////////////////////////////////////////////////////////
  xcom_rx_deser u_rx_deser (
    .c_clk_i    (c_clk_i),
    .c_rst_ni   (c_rst_ni),
    .i_xcom_clk (i_xcom_clk),
    .i_xcom_data(i_xcom_data),
    .o_valid    (rx_valid),
    .o_header   (rx_header),
    .o_data     (rx_data)
  );

  xcom_exec u_exec (
    .c_clk_i    (c_clk_i),
    .c_rst_ni   (c_rst_ni),
    .i_req_loc  (i_req_loc),
    .o_ack_loc  (o_ack_loc),
    .i_header   (i_header),
    .i_data     (i_data),
    .i_rx_valid (rx_valid),
    .i_rx_header(rx_header),
    .i_rx_data  (rx_data),
    .i_mem_addr (i_mem_addr),
    .o_mem_data (o_mem_data),
    .o_qp_vld   (o_qp_vld),
    .o_qp_flag  (o_qp_flag),
    .o_qp_dt1   (o_qp_dt1),
    .o_qp_dt2   (o_qp_dt2),
    .o_board_id (o_board_id)
  );

endmodule

/* vlog.f */
common/xcom_cmd_pkg.sv
common/xcom_link_pkg.sv
xcom_tx/xcom_tx_ser.sv
xcom_rx/xcom_rx_deser.sv
src/xcom_exec.sv
src/xcom_top.sv
dv/xcom_tb.sv

/* xcom_rx/xcom_rx_deser.sv */
// frame deserializer for one link input
// bits are taken on every toggle of the synchronized clock line
// the data line must settle together with the clock toggle
// o_valid is a single-cycle pulse and cannot be stalled
// toggles in idle with data 0 are padding and are dropped
module xcom_rx_deser
  import xcom_cmd_pkg::*;
  import xcom_link_pkg::*;
(
  input  logic    c_clk_i,
  input  logic    c_rst_ni,
  input  logic    i_xcom_clk,
  input  logic    i_xcom_data,
  output logic    o_valid,
  output header_t o_header,
  output word_t   o_data
);

  typedef enum logic [1:0] {RX_IDLE, RX_HDR, RX_PAY} rx_state_e;

  logic [SYNC_STAGES-1:0] clk_sync_q;
  logic [SYNC_STAGES-1:0] dat_sync_q;
  logic                   clk_d_q;
  logic                   edge_det;
  logic                   bit_in;
  rx_state_e              state_q;
  bit_cnt_t               cnt_q;
  bit_cnt_t               pay_bits;
  header_t                hdr_sh_q;
  header_t                hdr_next;
  word_t                  pay_sh_q;
  word_t                  pay_next;
  len_code_t              len;
  logic                   hdr_done;
  logic                   pay_done;
  logic                   frame_done;

  ////////////////////////////////////////////////////////////
  // input sync and toggle detect
  ////////////////////////////////////////////////////////////
  always_ff @(posedge c_clk_i or negedge c_rst_ni) begin
    if (!c_rst_ni) begin
      clk_sync_q <= '0;
      dat_sync_q <= '0;
      clk_d_q    <= 1'b0;
    end else begin
      clk_sync_q <= {clk_sync_q[SYNC_STAGES-2:0], i_xcom_clk};
      dat_sync_q <= {dat_sync_q[SYNC_STAGES-2:0], i_xcom_data};
      clk_d_q    <= clk_sync_q[SYNC_STAGES-1];
    end
  end

  // either edge of the line clock carries a bit
  assign edge_det = clk_sync_q[SYNC_STAGES-1] ^ clk_d_q;
  assign bit_in   = dat_sync_q[SYNC_STAGES-1];

  ////////////////////////////////////////////////////////////
  // shift paths
  ////////////////////////////////////////////////////////////
  assign hdr_next = {hdr_sh_q[HDR_W-2:0], bit_in};
  assign pay_next = {pay_sh_q[WORD_W-2:0], bit_in};
  assign len      = hdr_next[HDR_LEN_MSB:HDR_LEN_LSB];

  always_comb begin
    case (len)
      LEN_8:   pay_bits = bit_cnt_t'(8);
      LEN_16:  pay_bits = bit_cnt_t'(16);
      default: pay_bits = bit_cnt_t'(WORD_W);
    endcase
  end

  assign hdr_done   = (state_q == RX_HDR) && edge_det && (cnt_q == bit_cnt_t'(1));
  assign pay_done   = (state_q == RX_PAY) && edge_det && (cnt_q == bit_cnt_t'(1));
  assign frame_done = (hdr_done && (len == LEN_NONE)) || pay_done;

  // cleared outside the payload so short words come out zero-extended
  always_ff @(posedge c_clk_i) begin
    if (state_q != RX_PAY) begin
      pay_sh_q <= '0;
    end else if (edge_det) begin
      pay_sh_q <= pay_next;
    end
    if ((state_q == RX_HDR) && edge_det) begin
      hdr_sh_q <= hdr_next;
    end
    if (frame_done) begin
      o_header <= hdr_done ? hdr_next : hdr_sh_q;
      o_data   <= pay_done ? pay_next : '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // frame FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge c_clk_i or negedge c_rst_ni) begin
    if (!c_rst_ni) begin
      state_q <= RX_IDLE;
      cnt_q   <= '0;
      o_valid <= 1'b0;
    end else begin
      o_valid <= frame_done;
      case (state_q)
        RX_IDLE: begin
          // start bit is the only toggle with data 1 in idle
          if (edge_det && bit_in) begin
            cnt_q   <= bit_cnt_t'(HDR_W);
            state_q <= RX_HDR;
          end
        end
        RX_HDR: begin
          if (edge_det) begin
            cnt_q <= cnt_q - bit_cnt_t'(1);
            if (hdr_done) begin
              cnt_q   <= pay_bits;
              state_q <= (len == LEN_NONE) ? RX_IDLE : RX_PAY;
            end
          end
        end
        RX_PAY: begin
          if (edge_det) begin
            cnt_q <= cnt_q - bit_cnt_t'(1);
            if (pay_done) state_q <= RX_IDLE;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

endmodule

/* xcom_tx/xcom_tx_ser.sv */
// frame serializer, one bit per toggle of o_xcom_clk
// i_cfg_tick must stay stable while a frame is in flight
// requests arriving during a frame wait until the FSM is idle again
// an odd toggle count gets one padding toggle with data 0
module xcom_tx_ser
  import xcom_cmd_pkg::*;
  import xcom_link_pkg::*;
(
  input  logic    c_clk_i,
  input  logic    c_rst_ni,
  input  tick_t   i_cfg_tick,
  input  logic    i_req,
  input  header_t i_header,
  input  word_t   i_data,
  output logic    o_ack,
  output logic    o_busy,
  output logic    o_xcom_clk,
  output logic    o_xcom_data
);

  typedef enum logic [1:0] {TX_IDLE, TX_LOAD, TX_SHIFT, TX_TAIL} tx_state_e;

  tx_state_e          state_q;
  header_t            hdr_q;
  word_t              data_q;
  logic [FRAME_W-1:0] sh_q;
  bit_cnt_t           bits_q;
  tick_t              per_q;
  logic               accept;
  logic               toggle_en;
  len_code_t          len;
  word_t              pay_aligned;
  bit_cnt_t           frame_bits;

  ////////////////////////////////////////////////////////////
  // network handshake
  ////////////////////////////////////////////////////////////
  assign accept = i_req & ~o_ack & (state_q == TX_IDLE);
  assign o_busy = (state_q != TX_IDLE);

  always_ff @(posedge c_clk_i or negedge c_rst_ni) begin
    if (!c_rst_ni) begin
      o_ack <= 1'b0;
    end else if (accept) begin
      o_ack <= 1'b1;
    end else if (!i_req && o_ack) begin
      o_ack <= 1'b0;
    end
  end

  // command capture
  always_ff @(posedge c_clk_i) begin
    if (accept) begin
      hdr_q  <= i_header;
      data_q <= i_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // frame build
  ////////////////////////////////////////////////////////////
  assign len = hdr_q[HDR_LEN_MSB:HDR_LEN_LSB];

  // payload moved to the top so it leaves MSB first
  always_comb begin
    case (len)
      LEN_NONE: begin
        pay_aligned = '0;
        frame_bits  = bit_cnt_t'(9);
      end
      LEN_8: begin
        pay_aligned = {data_q[7:0], 24'd0};
        frame_bits  = bit_cnt_t'(17);
      end
      LEN_16: begin
        pay_aligned = {data_q[15:0], 16'd0};
        frame_bits  = bit_cnt_t'(25);
      end
      default: begin
        pay_aligned = data_q;
        frame_bits  = bit_cnt_t'(FRAME_W);
      end
    endcase
  end

  assign toggle_en = (state_q == TX_SHIFT) && (per_q == '0);

  always_ff @(posedge c_clk_i) begin
    if (state_q == TX_LOAD) begin
      sh_q <= {1'b1, hdr_q, pay_aligned};
    end else if (toggle_en) begin
      sh_q <= {sh_q[FRAME_W-2:0], 1'b0};
    end
  end

  ////////////////////////////////////////////////////////////
  // toggle FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge c_clk_i or negedge c_rst_ni) begin
    if (!c_rst_ni) begin
      state_q     <= TX_IDLE;
      bits_q      <= '0;
      per_q       <= '0;
      o_xcom_clk  <= 1'b0;
      o_xcom_data <= 1'b0;
    end else begin
      case (state_q)
        TX_IDLE: begin
          // data line parks low between frames
          o_xcom_data <= 1'b0;
          if (accept) state_q <= TX_LOAD;
        end
        TX_LOAD: begin
          bits_q  <= frame_bits;
          per_q   <= '0;
          state_q <= TX_SHIFT;
        end
        TX_SHIFT: begin
          if (toggle_en) begin
            o_xcom_clk  <= ~o_xcom_clk;
            o_xcom_data <= sh_q[FRAME_W-1];
            bits_q      <= bits_q - bit_cnt_t'(1);
            per_q       <= i_cfg_tick + tick_t'(1);
            // last bit, clock high after it needs the tail
            if (bits_q == bit_cnt_t'(1)) begin
              state_q <= o_xcom_clk ? TX_IDLE : TX_TAIL;
            end
          end else begin
            per_q <= per_q - tick_t'(1);
          end
        end
        TX_TAIL: begin
          if (per_q == '0) begin
            o_xcom_clk  <= 1'b0;
            o_xcom_data <= 1'b0;
            state_q     <= TX_IDLE;
          end else begin
            per_q <= per_q - tick_t'(1);
          end
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

endmodule
